//--- design/dz_pkg.sv
package dz_pkg;

    // matrix geometry, fixed by the glyph table
    localparam int dz_rows  = 8;
    localparam int dz_row_w = 3;

    // image numbers of the red-only pictures
    localparam logic [3:0] dz_img_red_a = 4'd8;
    localparam logic [3:0] dz_img_red_b = 4'd11;

    // image command from the game controller
    typedef struct packed {
        logic [3:0] num;  // image number
        logic       fail; // player has lost
    } dz_cmd_t;

    // green and red column planes for one row
    typedef struct packed {
        logic [dz_rows-1:0] colg;
        logic [dz_rows-1:0] colr;
    } dz_cols_t;

endpackage

//--- design/dz_ctrl.sv
`timescale 1ns/100ps

module dz_ctrl
(
    input  logic           clk,
    input  logic           st,
    input  logic           req,
    input  dz_pkg::dz_cmd_t cmd,
    output logic           ack,
    output dz_pkg::dz_cmd_t frame
);

    typedef enum logic {
        s_idle,
        s_ack
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            state <= s_idle;
            frame <= '0;
        end
        else
        begin
            case (state)
                s_idle:
                begin
                    if (req)
                    begin
                        state <= s_ack;
                        frame <= cmd; // only load point
                    end
                end
                s_ack:
                begin
                    if (!req)
                        state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    assign ack = (state == s_ack);

endmodule

//--- design/dz_scan.sv
`timescale 1ns/100ps

module dz_scan
(
    input  logic                       clk,
    input  logic                       st,
    output logic [dz_pkg::dz_row_w-1:0] row_idx,
    output logic [dz_pkg::dz_rows-1:0]  row
);

    // one-hot select for the current index, active low
    logic [dz_pkg::dz_rows-1:0] row_sel;

    assign row_sel = ~(dz_pkg::dz_rows'(1) << row_idx);

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            row_idx <= '0;
            row     <= '1; // all rows off
        end
        else
        begin
            row_idx <= row_idx + 1'b1; // wraps 7 -> 0
            row     <= row_sel;
        end
    end

endmodule

//--- design/dz_glyph_rom.sv
`timescale 1ns/100ps

module dz_glyph_rom
(
    input  logic [3:0]                  num,
    input  logic [dz_pkg::dz_row_w-1:0] row_idx,
    output dz_pkg::dz_cols_t            raw
);

    logic [dz_pkg::dz_rows-1:0] g;
    logic [dz_pkg::dz_rows-1:0] r;

    always_comb
    begin
        g = '0;
        r = '0;
        case (num)
            // growing blob, images 0 to 5
            4'd0:
            begin
                case (row_idx)
                    3'd2, 3'd5: g = 8'b0001_1000;
                    3'd3, 3'd4: g = 8'b0011_1100;
                    default:    g = '0;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: g = 8'b0011_1000;
                    3'd3, 3'd4: g = 8'b0111_1100;
                    default:    g = '0;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd2, 3'd5: g = 8'b0011_1100;
                    3'd3, 3'd4: g = 8'b0111_1110;
                    default:    g = '0;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             g = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: g = 8'b0111_1110;
                    default:                g = '0;
                endcase
            end
            4'd4:
            begin
                case (row_idx)
                    3'd0, 3'd7: g = 8'b0011_1100;
                    3'd1, 3'd6: g = 8'b0111_1110;
                    default:    g = 8'b1111_1111;
                endcase
            end
            4'd5: g = 8'b1111_1111; // full square
            4'd6:
            begin
                case (row_idx)
                    3'd0: g = 8'b1100_0011;
                    3'd1: g = 8'b1110_0011;
                    3'd2: g = 8'b1111_0001;
                    3'd3: g = 8'b1110_0011;
                    3'd4: g = 8'b1100_0111;
                    3'd5: g = 8'b1110_0111;
                    3'd6: g = 8'b1111_0111;
                    3'd7: g = 8'b1111_1011;
                endcase
            end
            4'd7:
            begin
                case (row_idx)
                    3'd1:    g = 8'b0000_0001;
                    3'd2:    g = 8'b1000_0001;
                    3'd3:    g = 8'b1100_0011;
                    3'd4:    g = 8'b1000_0011;
                    3'd5:    g = 8'b1100_0111;
                    3'd6:    g = 8'b1110_0111;
                    3'd7:    g = 8'b1111_0011;
                    default: g = '0;
                endcase
            end
            dz_pkg::dz_img_red_a:
            begin
                case (row_idx)
                    3'd1:    r = 8'b0011_1000;
                    3'd2:    r = 8'b0100_0100;
                    3'd3:    r = 8'b0101_1010;
                    3'd4:    r = 8'b0100_1010;
                    3'd5:    r = 8'b0011_0010;
                    3'd6:    r = 8'b1100_0100;
                    3'd7:    r = 8'b0011_1000;
                    default: r = '0;
                endcase
            end
            4'd9:
            begin
                case (row_idx)
                    3'd2:    g = 8'b0110_0000;
                    3'd3:    g = 8'b1111_1100;
                    3'd4:    g = 8'b0011_1111;
                    3'd5:    g = 8'b0011_1110;
                    3'd6:    g = 8'b0001_1100;
                    default: g = '0;
                endcase
            end
            4'd10:
            begin
                case (row_idx)
                    3'd2:       g = 8'b0001_1000;
                    3'd3:       g = 8'b0011_1100;
                    3'd4, 3'd5: g = 8'b0111_1110;
                    3'd6:       g = 8'b0010_0100;
                    default:    g = '0;
                endcase
            end
            dz_pkg::dz_img_red_b:
            begin
                case (row_idx)
                    3'd0: r = 8'b1110_0000;
                    3'd1: r = 8'b0110_0000;
                    3'd2: r = 8'b1110_0000;
                    3'd3: r = 8'b0011_0000;
                    3'd4: r = 8'b0011_0001;
                    3'd5: r = 8'b0011_0011;
                    3'd6: r = 8'b0011_1110;
                    3'd7: r = 8'b0001_1100;
                endcase
            end
            default:
            begin
                g = '0; // 12 to 15 blank
                r = '0;
            end
        endcase
    end

    assign raw = '{colg: g, colr: r};

endmodule

//--- design/dz_color_mix.sv
`timescale 1ns/100ps

module dz_color_mix
(
    input  logic             clk,
    input  logic             st,
    input  dz_pkg::dz_cmd_t  frame,
    input  dz_pkg::dz_cols_t raw,
    output dz_pkg::dz_cols_t cols
);

    logic                       red_only;
    logic                       copy_g;
    logic [dz_pkg::dz_rows-1:0] red;

    assign red_only = (frame.num == dz_pkg::dz_img_red_a) ||
                      (frame.num == dz_pkg::dz_img_red_b);

    // which green images also light red, giving yellow
    always_comb
    begin
        case (frame.num)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: copy_g = !frame.fail;
            4'd6, 4'd7, 4'd9:                   copy_g = 1'b1;
            default:                            copy_g = 1'b0;
        endcase
    end

    assign red = red_only ? raw.colr :
                 copy_g   ? raw.colg : '0;

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
            cols <= '0;
        else
        begin
            cols.colg <= raw.colg;
            cols.colr <= red; // same edge as green and row
        end
    end

endmodule

//--- design/dz_matrix_top.sv
`timescale 1ns/100ps

module dz_matrix_top
(
    input  logic                      clk,
    input  logic                      st,
    input  logic                      req,
    input  dz_pkg::dz_cmd_t           cmd,
    output logic                      ack,
    output logic [dz_pkg::dz_rows-1:0] row,
    output dz_pkg::dz_cols_t          cols
);

    dz_pkg::dz_cmd_t             frame;
    logic [dz_pkg::dz_row_w-1:0] row_idx;
    dz_pkg::dz_cols_t            raw;

    dz_ctrl u_ctrl (
        .clk   (clk),
        .st    (st),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .frame (frame)
    );

    dz_scan u_scan (
        .clk     (clk),
        .st      (st),
        .row_idx (row_idx),
        .row     (row)
    );

    dz_glyph_rom u_rom (
        .num     (frame.num),
        .row_idx (row_idx),
        .raw     (raw)
    );

    dz_color_mix u_mix (
        .clk   (clk),
        .st    (st),
        .frame (frame),
        .raw   (raw),
        .cols  (cols)
    );

endmodule

//--- dv/dz_sva.sv
`timescale 1ns/100ps

module dz_sva
(
    input logic             clk,
    input logic             st,
    input logic             req,
    input logic             ack,
    input logic [7:0]       row,
    input dz_pkg::dz_cols_t cols
);

    // one row lit once the scanner has stepped
    row_one_hot: assert property (@(posedge clk) disable iff (!st)
        $past(st) |-> $onehot(~row))
        else $error("row select is not one-hot low");

    ack_hold: assert property (@(posedge clk) disable iff (!st)
        ack && req |=> ack)
        else $error("ack fell while req was still high");

    cols_reset: assert property (@(posedge clk) !st |-> cols == '0)
        else $error("column planes not blank during reset");

endmodule

bind dz_matrix_top dz_sva u_sva (.clk(clk), .st(st), .req(req), .ack(ack),
                                 .row(row), .cols(cols));

//--- dv/dz_checker.sv
`timescale 1ns/100ps

module dz_checker
(
    input  logic             clk,
    input  logic             st,
    input  logic             ack,
    input  logic [7:0]       row,
    input  dz_pkg::dz_cols_t cols,
    input  int               line_idx,
    output int               err_cnt
);

    localparam int max_lines = 32;
    localparam int line_w    = 18;

    logic [7:0] pats [0:max_lines*line_w-1];
    int         edges;        // edges since reset release
    int         cur   = -1;   // line shown on the matrix
    int         errs  = 0;
    logic       ack_q = 1'b0;

    assign err_cnt = errs;

    initial
    begin
        for (int i = 0; i < max_lines*line_w; i++)
            pats[i] = '0;
        $readmemh("dv/dz_patterns.txt", pats);
    end

    // position of the single low bit, -1 when not one-hot low
    function automatic int low_bit(input logic [7:0] r);
        int idx;
        idx = -1;
        for (int b = 0; b < 8; b++)
            if (r == ~(8'h01 << b))
                idx = b;
        return idx;
    endfunction

    task automatic compare(input string name, input string what, input int exp, input int act);
        if (exp != act)
        begin
            $display("[FAIL] test %s %s: expected %0h actual %0h", name, what, exp, act);
            errs++;
        end
    endtask

    always @(posedge clk or negedge st)
    begin
        if (!st)
            edges <= 0;
        else
            edges <= edges + 1;
    end

    always @(negedge clk)
    begin
        int    k;
        string name;
        name = (cur < 0) ? "scan" : $sformatf("%0h", pats[cur*line_w]);
        if (edges == 0)
        begin
            compare("reset", "row", 255, int'(row));
            compare("reset", "cols", 0, int'(cols));
            compare("reset", "ack", 0, int'(ack));
        end
        else
        begin
            k = (edges - 1) % dz_pkg::dz_rows;
            if (low_bit(row) < 0)
            begin
                $display("error: row select %08b does not have exactly one low bit", row);
                errs++;
            end
            else
                compare(name, "row index", k, low_bit(row));
            if (cur >= 0)
            begin
                compare(name, "green", int'(pats[cur*line_w + 2 + k]), int'(cols.colg));
                compare(name, "red", int'(pats[cur*line_w + 10 + k]), int'(cols.colr));
            end
        end
        if (ack && !ack_q)
            cur = line_idx; // new frame on the pins from the next edge
        ack_q = ack;
    end

endmodule

//--- dv/dz_tb.sv
`timescale 1ns/100ps

module dz_tb;

    localparam int max_lines = 32;
    localparam int line_w    = 18; // id, cmd, 8 green rows, 8 red rows

    logic             clk      = 1'b0;
    logic             st;
    logic             req;
    dz_pkg::dz_cmd_t  cmd;
    logic             ack;
    logic [7:0]       row;
    dz_pkg::dz_cols_t cols;
    logic [7:0]       pats [0:max_lines*line_w-1];
    int               n_lines  = 0;
    int               line_idx;
    int               chk_errs;
    int               hs_errs  = 0;
    logic             loaded   = 1'b0;

    dz_matrix_top UUT (.clk(clk), .st(st), .req(req), .cmd(cmd),
                       .ack(ack), .row(row), .cols(cols));

    dz_checker u_checker (.clk(clk), .st(st), .ack(ack), .row(row), .cols(cols),
                          .line_idx(line_idx), .err_cnt(chk_errs));

    initial
    begin
        forever #4 clk = ~clk;
    end

    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (ack !== level && n < 16)
        begin
            @(negedge clk);
            n++;
        end
        if (ack !== level)
        begin
            $display("handshake error: ack did not %s for line %0d", what, line_idx);
            hs_errs++;
        end
    endtask

    // one four-phase handshake, then three full scans of the frame
    task automatic run_line(input int idx);
        int base;
        base = idx * line_w;
        @(negedge clk);
        line_idx <= idx;
        cmd      <= dz_pkg::dz_cmd_t'(pats[base+1][4:0]);
        req      <= 1'b1;
        @(negedge clk);
        wait_ack(1'b1, "rise");
        cmd <= ~cmd; // frame must keep the captured command
        @(negedge clk);
        req <= 1'b0;
        @(negedge clk);
        wait_ack(1'b0, "fall");
        repeat (3 * dz_pkg::dz_rows) @(negedge clk);
    endtask

    initial
    begin
        st       <= 1'b0;
        req      <= 1'b0;
        cmd      <= '0;
        line_idx <= -1;
        for (int i = 0; i < max_lines*line_w; i++)
            pats[i] = '0;
        $readmemh("dv/dz_patterns.txt", pats);
        while (n_lines < max_lines && pats[n_lines*line_w] != 8'h00)
            n_lines++;
        loaded = 1'b1;
        repeat (2) @(posedge clk); // two cycles in reset
        @(negedge clk);
        st <= 1'b1;
        for (int i = 0; i < n_lines; i++)
            run_line(i);
        repeat (4) @(negedge clk);
        $display("errors: %0d check, %0d handshake, over %0d tests", chk_errs, hs_errs, n_lines);
        if (chk_errs == 0 && hs_errs == 0 && n_lines > 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        wait (loaded);
        repeat (n_lines * 40 + 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", n_lines * 40 + 100);
        $display("Test failed");
        $finish;
    end

endmodule

//--- dv/dz_patterns.txt
// id, cmd {num,fail}, green rows 0 to 7, red rows 0 to 7
01 00 00 00 18 3c 3c 18 00 00 00 00 18 3c 3c 18 00 00
02 04 00 00 3c 7e 7e 3c 00 00 00 00 3c 7e 7e 3c 00 00
03 06 00 3c 7e 7e 7e 7e 3c 00 00 3c 7e 7e 7e 7e 3c 00
04 09 3c 7e ff ff ff ff 7e 3c 00 00 00 00 00 00 00 00
05 0a ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
06 0c c3 e3 f1 e3 c7 e7 f7 fb c3 e3 f1 e3 c7 e7 f7 fb
07 0d c3 e3 f1 e3 c7 e7 f7 fb c3 e3 f1 e3 c7 e7 f7 fb
08 0f 00 01 81 c3 83 c7 e7 f3 00 01 81 c3 83 c7 e7 f3
09 13 00 00 60 fc 3f 3e 1c 00 00 00 60 fc 3f 3e 1c 00
0a 14 00 00 18 3c 7e 7e 24 00 00 00 00 00 00 00 00 00
0b 10 00 00 00 00 00 00 00 00 00 38 44 5a 4a 32 c4 38
0c 17 00 00 00 00 00 00 00 00 e0 60 e0 30 31 33 3e 1c
0d 1a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0e 11 00 00 00 00 00 00 00 00 00 38 44 5a 4a 32 c4 38
0f 1f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

//--- dz_matrix.f
design/dz_pkg.sv
design/dz_ctrl.sv
design/dz_scan.sv
design/dz_glyph_rom.sv
design/dz_color_mix.sv
design/dz_matrix_top.sv
dv/dz_sva.sv
dv/dz_checker.sv
dv/dz_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module dz_tb -f dz_matrix.f -o dz_sim \
    && ./obj_dir/dz_sim | tee sim.log
grep -q "^Test passed$" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
